//--- build.f
+incdir+include
rtl/ex_pkg.sv
rtl/ex_alu.sv
rtl/ex_branch_unit.sv
rtl/ex_csr_buffer.sv
rtl/ex_mult.sv
rtl/ex_sfence_capture.sv
rtl/ex_flu.sv
rtl/ex_stage.sv
test/tb_ex_stage.sv

//--- rtl/ex_alu.sv
// Combinational ALU for arithmetic, logic, shifts and branch compares
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
    input  ex_pkg::fu_data_t        fu_data_i,
    output logic [ex_pkg::XLEN-1:0] result_o,
    output logic                    branch_cmp_o
);

    logic [ex_pkg::XLEN-1:0] op_a;
    logic [ex_pkg::XLEN-1:0] op_b;
    logic [4:0]              shamt;
    logic                    less_u;
    logic                    equal;

    assign op_a  = fu_data_i.operand_a;
    assign op_b  = fu_data_i.operand_b;
    // Shift amount from low bits of rs2
    assign shamt = op_b[4:0];

    // Shared unsigned compare
    assign less_u = op_a < op_b;
    assign equal  = op_a == op_b;

    // --------------------------------------------------
    // Result
    // --------------------------------------------------
    always_comb begin
        result_o = '0;
        case (fu_data_i.operator)
            ex_pkg::ADD:  result_o = op_a + op_b;
            ex_pkg::SUB:  result_o = op_a - op_b;
            ex_pkg::AND:  result_o = op_a & op_b;
            ex_pkg::OR:   result_o = op_a | op_b;
            ex_pkg::XOR:  result_o = op_a ^ op_b;
            ex_pkg::SLL:  result_o = op_a << shamt;
            ex_pkg::SRL:  result_o = op_a >> shamt;
            // Set on less than, zero extended
            ex_pkg::SLTU: result_o = {{(ex_pkg::XLEN-1){1'b0}}, less_u};
            default:      result_o = '0;
        endcase
    end

    // Branch condition, zero for non-branch ops
    always_comb begin
        case (fu_data_i.operator)
            ex_pkg::EQ:  branch_cmp_o = equal;
            ex_pkg::NE:  branch_cmp_o = ~equal;
            ex_pkg::LTU: branch_cmp_o = less_u;
            ex_pkg::GEU: branch_cmp_o = ~less_u;
            default:     branch_cmp_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/ex_branch_unit.sv
// Branch unit resolving targets, link address, mispredicts and misalignment
`timescale 1ns/1ps
`default_nettype none

module ex_branch_unit (
    input  ex_pkg::fu_data_t        fu_data_i,
    input  logic [ex_pkg::VLEN-1:0] pc_i,
    input  logic                    is_compressed_i,
    input  logic                    branch_valid_i,
    input  logic                    branch_cmp_i,
    input  ex_pkg::bp_predict_t     branch_predict_i,
    output logic [ex_pkg::VLEN-1:0] link_o,
    output ex_pkg::bp_resolve_t     resolved_branch_o,
    output logic                    resolve_branch_o,
    output ex_pkg::exception_t      exception_o
);

    logic                    is_jalr;
    logic                    taken;
    logic                    mispredict;
    logic [ex_pkg::VLEN-1:0] step;
    logic [ex_pkg::VLEN-1:0] base;
    logic [ex_pkg::VLEN-1:0] jump_sum;
    logic [ex_pkg::VLEN-1:0] jump_target;
    logic [ex_pkg::VLEN-1:0] target;

    assign is_jalr = fu_data_i.operator == ex_pkg::JALR;
    // Jumps always taken
    assign taken   = branch_cmp_i | is_jalr;

    // Next PC depends on instruction size
    assign step   = is_compressed_i ? 'd2 : 'd4;
    assign link_o = pc_i + step;

    // --------------------------------------------------
    // Target
    // --------------------------------------------------
    // JALR is register relative, branches PC relative
    assign base        = is_jalr ? fu_data_i.operand_a : pc_i;
    assign jump_sum    = base + fu_data_i.imm.offset;
    // JALR drops bit 0
    assign jump_target = {jump_sum[ex_pkg::VLEN-1:1], jump_sum[0] & ~is_jalr};
    assign target      = taken ? jump_target : link_o;

    // Wrong direction, or right direction to wrong address
    assign mispredict = (branch_predict_i.taken != taken) |
                        (taken & (branch_predict_i.predict_address != target));

    // --------------------------------------------------
    // Resolution
    // --------------------------------------------------
    assign resolve_branch_o                = branch_valid_i;
    assign resolved_branch_o.valid         = branch_valid_i;
    assign resolved_branch_o.pc            = pc_i;
    assign resolved_branch_o.target        = target;
    assign resolved_branch_o.is_taken      = taken;
    assign resolved_branch_o.is_mispredict = branch_valid_i & mispredict;

    // Odd target faults
    assign exception_o.valid = branch_valid_i & taken & target[0];
    assign exception_o.cause = ex_pkg::CAUSE_MISALIGNED_FETCH;
    assign exception_o.tval  = target;

endmodule

`default_nettype wire

//--- rtl/ex_csr_buffer.sv
// Single-entry CSR address buffer holding issue until commit or flush
`timescale 1ns/1ps
`default_nettype none

module ex_csr_buffer (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             flush_i,
    input  ex_pkg::fu_data_t                 fu_data_i,
    input  logic                             csr_valid_i,
    input  logic                             csr_commit_i,
    output logic                             csr_ready_o,
    output logic [ex_pkg::XLEN-1:0]          csr_result_o,
    output logic [ex_pkg::CSR_ADDR_BITS-1:0] csr_addr_o
);

    logic full_q;

    // Entry occupancy
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            full_q <= 1'b0;
        end else if (flush_i) begin
            full_q <= 1'b0;
        end else if (csr_valid_i) begin
            full_q <= 1'b1;
        end else if (csr_commit_i) begin
            full_q <= 1'b0;
        end
    end

    // Address from the CSR view of the immediate
    always_ff @(posedge clk_i) begin
        if (csr_valid_i) begin
            csr_addr_o <= fu_data_i.imm.csr.addr;
        end
    end

    // Write data goes back through the shared port
    assign csr_result_o = fu_data_i.operand_a;
    assign csr_ready_o  = ~full_q;

endmodule

`default_nettype wire

//--- rtl/ex_flu.sv
// Fixed-latency unit joining ALU, branch, CSR buffer and multiplier
`timescale 1ns/1ps
`default_nettype none

module ex_flu (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             flush_i,
    input  ex_pkg::fu_data_t                 fu_data_i,
    input  ex_pkg::issue_t                   issue_i,
    input  logic [ex_pkg::VLEN-1:0]          pc_i,
    input  logic                             is_compressed_i,
    input  ex_pkg::bp_predict_t              branch_predict_i,
    input  logic                             csr_commit_i,
    output logic [ex_pkg::XLEN-1:0]          flu_result_o,
    output logic [ex_pkg::TRANS_ID_BITS-1:0] flu_trans_id_o,
    output ex_pkg::exception_t               flu_exception_o,
    output logic                             flu_valid_o,
    output logic                             flu_ready_o,
    output ex_pkg::bp_resolve_t              resolved_branch_o,
    output logic                             resolve_branch_o,
    output logic [ex_pkg::CSR_ADDR_BITS-1:0] csr_addr_o
);

    ex_pkg::fu_data_t                 alu_data;
    ex_pkg::fu_data_t                 mult_data;
    logic [ex_pkg::XLEN-1:0]          alu_result;
    logic [ex_pkg::XLEN-1:0]          csr_result;
    logic [ex_pkg::XLEN-1:0]          mult_result;
    logic [ex_pkg::VLEN-1:0]          branch_link;
    logic [ex_pkg::TRANS_ID_BITS-1:0] mult_trans_id;
    logic                             alu_branch_cmp;
    logic                             mult_valid;

    // --------------------------------------------------
    // Operand silencing
    // --------------------------------------------------
    // Idle units see zeros and do not toggle
    assign alu_data  = (issue_i.alu | issue_i.branch) ? fu_data_i : '0;
    assign mult_data = issue_i.mult ? fu_data_i : '0;

    ex_alu u_alu (
        .fu_data_i    (alu_data),
        .result_o     (alu_result),
        .branch_cmp_o (alu_branch_cmp)
    );

    // Raw operands, keeps the target path short
    ex_branch_unit u_branch_unit (
        .fu_data_i         (fu_data_i),
        .pc_i              (pc_i),
        .is_compressed_i   (is_compressed_i),
        .branch_valid_i    (issue_i.branch),
        .branch_cmp_i      (alu_branch_cmp),
        .branch_predict_i  (branch_predict_i),
        .link_o            (branch_link),
        .resolved_branch_o (resolved_branch_o),
        .resolve_branch_o  (resolve_branch_o),
        .exception_o       (flu_exception_o)
    );

    ex_csr_buffer u_csr_buffer (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .fu_data_i    (fu_data_i),
        .csr_valid_i  (issue_i.csr),
        .csr_commit_i (csr_commit_i),
        .csr_ready_o  (flu_ready_o),
        .csr_result_o (csr_result),
        .csr_addr_o   (csr_addr_o)
    );

    ex_mult u_mult (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .fu_data_i    (mult_data),
        .mult_valid_i (issue_i.mult),
        .result_o     (mult_result),
        .trans_id_o   (mult_trans_id),
        .valid_o      (mult_valid)
    );

    // --------------------------------------------------
    // Write port
    // --------------------------------------------------
    assign flu_valid_o = issue_i.alu | issue_i.branch | issue_i.csr | mult_valid;

    // ALU first, then CSR, then multiplier, link by default
    always_comb begin
        flu_result_o   = ex_pkg::XLEN'(branch_link);
        flu_trans_id_o = fu_data_i.trans_id;
        if (issue_i.alu) begin
            flu_result_o = alu_result;
        end else if (issue_i.csr) begin
            flu_result_o = csr_result;
        end else if (mult_valid) begin
            flu_result_o   = mult_result;
            // ID of the instruction issued last cycle
            flu_trans_id_o = mult_trans_id;
        end
    end

endmodule

`default_nettype wire

//--- rtl/ex_mult.sv
// One-cycle pipelined multiplier for MUL and MULHU
`timescale 1ns/1ps
`default_nettype none

module ex_mult (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             flush_i,
    input  ex_pkg::fu_data_t                 fu_data_i,
    input  logic                             mult_valid_i,
    output logic [ex_pkg::XLEN-1:0]          result_o,
    output logic [ex_pkg::TRANS_ID_BITS-1:0] trans_id_o,
    output logic                             valid_o
);

    logic [2*ex_pkg::XLEN-1:0] product;
    logic                      high_half;

    // Full unsigned product
    assign product = {{ex_pkg::XLEN{1'b0}}, fu_data_i.operand_a} *
                     {{ex_pkg::XLEN{1'b0}}, fu_data_i.operand_b};
    assign high_half = fu_data_i.operator == ex_pkg::MULHU;

    // Valid stage, killed by flush
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= mult_valid_i & ~flush_i;
        end
    end

    // Product and ID, registered every cycle
    always_ff @(posedge clk_i) begin
        result_o   <= high_half ? product[2*ex_pkg::XLEN-1:ex_pkg::XLEN]
                                : product[ex_pkg::XLEN-1:0];
        trans_id_o <= fu_data_i.trans_id;
    end

endmodule

`default_nettype wire

//--- rtl/ex_pkg.sv
// Execute stage package with widths, operator encoding and port structs
`default_nettype none

package ex_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    localparam int unsigned XLEN          = 32;
    localparam int unsigned VLEN          = 32;
    localparam int unsigned TRANS_ID_BITS = 3;
    localparam int unsigned ASID_WIDTH    = 4;
    localparam int unsigned CSR_ADDR_BITS = 12;

    // Instruction address misaligned
    localparam logic [3:0] CAUSE_MISALIGNED_FETCH = 4'd0;

    // --------------------------------------------------
    // Operators
    // --------------------------------------------------
    typedef enum logic [4:0] {
        ADD, SUB, AND, OR, XOR, SLL, SRL, SLTU,
        // Branch compares
        EQ, NE, LTU, GEU,
        JALR,
        CSR_RW, SFENCE_VMA,
        MUL, MULHU
    } fu_op_e;

    // CSR view of the immediate word
    typedef struct packed {
        logic [XLEN-CSR_ADDR_BITS-1:0] pad;
        logic [CSR_ADDR_BITS-1:0]      addr;
    } csr_imm_t;

    // Same word, branch offset or CSR address
    typedef union packed {
        logic signed [XLEN-1:0] offset;
        csr_imm_t               csr;
    } fu_imm_u;

    // --------------------------------------------------
    // Port structs
    // --------------------------------------------------
    typedef struct packed {
        fu_op_e                   operator;
        logic [XLEN-1:0]          operand_a;
        logic [XLEN-1:0]          operand_b;
        fu_imm_u                  imm;
        logic [TRANS_ID_BITS-1:0] trans_id;
    } fu_data_t;

    // From the frontend predictor
    typedef struct packed {
        logic            taken;
        logic [VLEN-1:0] predict_address;
    } bp_predict_t;

    // Back to the frontend
    typedef struct packed {
        logic            valid;
        logic [VLEN-1:0] pc;
        logic [VLEN-1:0] target;
        logic            is_taken;
        logic            is_mispredict;
    } bp_resolve_t;

    typedef struct packed {
        logic            valid;
        logic [3:0]      cause;
        logic [XLEN-1:0] tval;
    } exception_t;

    // One-hot issue strobes
    typedef struct packed {
        logic alu;
        logic branch;
        logic csr;
        logic mult;
    } issue_t;

endpackage

`default_nettype wire

//--- rtl/ex_sfence_capture.sv
// SFENCE.VMA operand capture holding address and ASID until flush
`timescale 1ns/1ps
`default_nettype none

module ex_sfence_capture (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          flush_i,
    input  ex_pkg::fu_data_t              fu_data_i,
    input  logic                          csr_valid_i,
    input  logic [ex_pkg::VLEN-1:0]       rs1_i,
    input  logic [ex_pkg::VLEN-1:0]       rs2_i,
    output logic [ex_pkg::VLEN-1:0]       vaddr_o,
    output logic [ex_pkg::ASID_WIDTH-1:0] asid_o
);

    logic is_sfence;
    logic pending_q;

    assign is_sfence = csr_valid_i & (fu_data_i.operator == ex_pkg::SFENCE_VMA);

    // Set on SFENCE issue, cleared by flush only
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pending_q <= 1'b0;
        end else if (flush_i) begin
            pending_q <= 1'b0;
        end else if (is_sfence) begin
            pending_q <= 1'b1;
        end
    end

    // Track forwarded operands, freeze from the issue cycle on
    always_ff @(posedge clk_i) begin
        if (!pending_q && !is_sfence) begin
            vaddr_o <= rs1_i;
            asid_o  <= rs2_i[ex_pkg::ASID_WIDTH-1:0];
        end
    end

endmodule

`default_nettype wire

//--- rtl/ex_stage.sv
// Execute stage top with the fixed-latency unit and SFENCE operand capture
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             flush_i,
    input  ex_pkg::fu_data_t                 fu_data_i,
    input  ex_pkg::issue_t                   issue_i,
    input  logic [ex_pkg::VLEN-1:0]          pc_i,
    input  logic                             is_compressed_i,
    input  ex_pkg::bp_predict_t              branch_predict_i,
    input  logic                             csr_commit_i,
    input  logic [ex_pkg::VLEN-1:0]          rs1_forwarding_i,
    input  logic [ex_pkg::VLEN-1:0]          rs2_forwarding_i,
    output logic [ex_pkg::XLEN-1:0]          flu_result_o,
    output logic [ex_pkg::TRANS_ID_BITS-1:0] flu_trans_id_o,
    output ex_pkg::exception_t               flu_exception_o,
    output logic                             flu_valid_o,
    output logic                             flu_ready_o,
    output ex_pkg::bp_resolve_t              resolved_branch_o,
    output logic                             resolve_branch_o,
    output logic [ex_pkg::CSR_ADDR_BITS-1:0] csr_addr_o,
    output logic [ex_pkg::VLEN-1:0]          sfence_vaddr_o,
    output logic [ex_pkg::ASID_WIDTH-1:0]    sfence_asid_o
);

    // Shared issue and write port
    ex_flu u_flu (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .flush_i           (flush_i),
        .fu_data_i         (fu_data_i),
        .issue_i           (issue_i),
        .pc_i              (pc_i),
        .is_compressed_i   (is_compressed_i),
        .branch_predict_i  (branch_predict_i),
        .csr_commit_i      (csr_commit_i),
        .flu_result_o      (flu_result_o),
        .flu_trans_id_o    (flu_trans_id_o),
        .flu_exception_o   (flu_exception_o),
        .flu_valid_o       (flu_valid_o),
        .flu_ready_o       (flu_ready_o),
        .resolved_branch_o (resolved_branch_o),
        .resolve_branch_o  (resolve_branch_o),
        .csr_addr_o        (csr_addr_o)
    );

    // SFENCE goes through the CSR strobe
    ex_sfence_capture u_sfence_capture (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .flush_i     (flush_i),
        .fu_data_i   (fu_data_i),
        .csr_valid_i (issue_i.csr),
        .rs1_i       (rs1_forwarding_i),
        .rs2_i       (rs2_forwarding_i),
        .vaddr_o     (sfence_vaddr_o),
        .asid_o      (sfence_asid_o)
    );

endmodule

`default_nettype wire

//--- include/tb_ex_vectors.svh
// Execute stage test vectors, one row per clock cycle
`ifndef TB_EX_VECTORS_SVH
`define TB_EX_VECTORS_SVH

// Check mask bits
localparam int M_VALID  = 1;
localparam int M_RESULT = 2;
localparam int M_TID    = 4;
localparam int M_READY  = 8;
localparam int M_BRANCH = 16;
localparam int M_CSR    = 32;
localparam int M_SFENCE = 64;

// Stimulus first, expected values after the rnd flag
typedef struct {
    string         name;
    ex_pkg::fu_op_e op;
    logic [31:0]   a;
    logic [31:0]   b;
    logic [31:0]   imm;
    logic [2:0]    tid;
    logic [3:0]    issue;
    logic [31:0]   pc;
    logic          cmpr;
    logic          pt;
    logic [31:0]   pa;
    logic [31:0]   rs1;
    logic [31:0]   rs2;
    logic          flush;
    logic          commit;
    logic          rnd;
    int            mask;
    logic          valid;
    logic [31:0]   result;
    logic [2:0]    rtid;
    logic          ready;
    logic [31:0]   target;
    logic          misp;
    logic          exc;
    logic [11:0]   csr;
    logic [31:0]   vaddr;
    logic [3:0]    asid;
} vec_row_t;

vec_row_t vectors[$];

task automatic load_vectors();
    // Issue bits are alu, branch, csr, mult
    vectors.push_back('{"idle_after_reset", ex_pkg::ADD, 0, 0, 0, 0, 4'b0000, 0, 0, 0, 0, 0, 0, 0, 0,
        0, M_VALID | M_READY, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0});
    // --------------------------------------------------
    // ALU, operands random
    // --------------------------------------------------
    vectors.push_back('{"alu_add", ex_pkg::ADD, 0, 0, 0, 0, 4'b1000, 0, 0, 0, 0, 0, 0, 0, 0,
        1, M_VALID | M_RESULT | M_TID, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0});
    vectors.push_back('{"alu_sub", ex_pkg::SUB, 0, 0, 0, 1, 4'b1000, 0, 0, 0, 0, 0, 0, 0, 0,
        1, M_VALID | M_RESULT | M_TID, 1, 0, 1, 0, 0, 0, 0, 0, 0, 0});
    vectors.push_back('{"alu_and", ex_pkg::AND, 0, 0, 0, 2, 4'b1000, 0, 0, 0, 0, 0, 0, 0, 0,
        1, M_VALID | M_RESULT | M_TID, 1, 0, 2, 0, 0, 0, 0, 0, 0, 0});
    vectors.push_back('{"alu_or", ex_pkg::OR, 0, 0, 0, 3, 4'b1000, 0, 0, 0, 0, 0, 0, 0, 0,
        1, M_VALID | M_RESULT | M_TID, 1, 0, 3, 0, 0, 0, 0, 0, 0, 0});
    vectors.push_back('{"alu_xor", ex_pkg::XOR, 0, 0, 0, 4, 4'b1000, 0, 0, 0, 0, 0, 0, 0, 0,
        1, M_VALID | M_RESULT | M_TID, 1, 0, 4, 0, 0, 0, 0, 0, 0, 0});
    vectors.push_back('{"alu_sll", ex_pkg::SLL, 0, 0, 0, 5, 4'b1000, 0, 0, 0, 0, 0, 0, 0, 0,
        1, M_VALID | M_RESULT | M_TID, 1, 0, 5, 0, 0, 0, 0, 0, 0, 0});
    vectors.push_back('{"alu_srl", ex_pkg::SRL, 0, 0, 0, 6, 4'b1000, 0, 0, 0, 0, 0, 0, 0, 0,
        1, M_VALID | M_RESULT | M_TID, 1, 0, 6, 0, 0, 0, 0, 0, 0, 0});
    vectors.push_back('{"alu_sltu", ex_pkg::SLTU, 0, 0, 0, 7, 4'b1000, 0, 0, 0, 0, 0, 0, 0, 0,
        1, M_VALID | M_RESULT | M_TID, 1, 0, 7, 0, 0, 0, 0, 0, 0, 0});
    // --------------------------------------------------
    // Branches, result is the link address
    // --------------------------------------------------
    vectors.push_back('{"br_eq_taken", ex_pkg::EQ, 5, 5, 16, 1, 4'b0100, 'h100, 0, 1, 'h110,
        0, 0, 0, 0, 0, M_VALID | M_RESULT | M_TID | M_BRANCH, 1, 'h104, 1, 0, 'h110, 0, 0,
        0, 0, 0});
    vectors.push_back('{"br_ne_not_taken", ex_pkg::NE, 5, 5, 16, 2, 4'b0100, 'h200, 1, 1, 'h210,
        0, 0, 0, 0, 0, M_VALID | M_RESULT | M_TID | M_BRANCH, 1, 'h202, 2, 0, 'h202, 1, 0,
        0, 0, 0});
    vectors.push_back('{"jalr", ex_pkg::JALR, 'h1001, 0, 6, 3, 4'b0100, 'h300, 0, 1, 'h1006,
        0, 0, 0, 0, 0, M_VALID | M_RESULT | M_TID | M_BRANCH, 1, 'h304, 3, 0, 'h1006, 0, 0,
        0, 0, 0});
    vectors.push_back('{"br_ltu_misaligned", ex_pkg::LTU, 1, 2, 'h11, 4, 4'b0100, 'h400, 0, 0,
        0, 0, 0, 0, 0, 0, M_VALID | M_RESULT | M_TID | M_BRANCH, 1, 'h404, 4, 0, 'h411, 1, 1,
        0, 0, 0});
    // --------------------------------------------------
    // CSR buffer
    // --------------------------------------------------
    vectors.push_back('{"csr_issue", ex_pkg::CSR_RW, 'hCAFE, 0, 'h342, 2, 4'b0010, 0, 0, 0, 0,
        0, 0, 0, 0, 0, M_VALID | M_RESULT | M_TID | M_READY, 1, 'hCAFE, 2, 1, 0, 0, 0, 0, 0, 0});
    vectors.push_back('{"csr_blocked", ex_pkg::ADD, 0, 0, 0, 0, 4'b0000, 0, 0, 0, 0, 0, 0, 0, 0,
        0, M_READY | M_CSR, 0, 0, 0, 0, 0, 0, 0, 'h342, 0, 0});
    vectors.push_back('{"csr_commit", ex_pkg::ADD, 0, 0, 0, 0, 4'b0000, 0, 0, 0, 0, 0, 0, 0, 1,
        0, M_READY, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0});
    vectors.push_back('{"csr_ready_again", ex_pkg::ADD, 0, 0, 0, 0, 4'b0000, 0, 0, 0, 0, 0, 0,
        0, 0, 0, M_READY, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0});
    vectors.push_back('{"csr_issue_2", ex_pkg::CSR_RW, 'h55, 0, 'h7C0, 3, 4'b0010, 0, 0, 0, 0,
        0, 0, 0, 0, 0, M_VALID | M_RESULT | M_TID | M_READY, 1, 'h55, 3, 1, 0, 0, 0, 0, 0, 0});
    vectors.push_back('{"csr_flush", ex_pkg::ADD, 0, 0, 0, 0, 4'b0000, 0, 0, 0, 0, 0, 0, 1, 0,
        0, M_READY | M_CSR, 0, 0, 0, 0, 0, 0, 0, 'h7C0, 0, 0});
    vectors.push_back('{"csr_flush_ready", ex_pkg::ADD, 0, 0, 0, 0, 4'b0000, 0, 0, 0, 0, 0, 0,
        0, 0, 0, M_READY, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0});
    // --------------------------------------------------
    // Multiplier, result one cycle after issue
    // --------------------------------------------------
    vectors.push_back('{"mul_issue", ex_pkg::MUL, 'h12345, 'h100, 0, 4, 4'b0001, 0, 0, 0, 0,
        0, 0, 0, 0, 0, M_VALID, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0});
    vectors.push_back('{"mulhu_issue", ex_pkg::MULHU, 'h80000000, 6, 0, 5, 4'b0001, 0, 0, 0, 0,
        0, 0, 0, 0, 0, M_VALID | M_RESULT | M_TID, 1, 'h1234500, 4, 0, 0, 0, 0, 0, 0, 0});
    vectors.push_back('{"mulhu_result", ex_pkg::ADD, 0, 0, 0, 0, 4'b0000, 0, 0, 0, 0, 0, 0, 0,
        0, 0, M_VALID | M_RESULT | M_TID, 1, 3, 5, 0, 0, 0, 0, 0, 0, 0});
    vectors.push_back('{"mul_flushed", ex_pkg::MUL, 7, 9, 0, 6, 4'b0001, 0, 0, 0, 0, 0, 0, 1, 0,
        0, M_VALID, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0});
    vectors.push_back('{"mul_suppressed", ex_pkg::ADD, 0, 0, 0, 0, 4'b0000, 0, 0, 0, 0, 0, 0, 0,
        0, 0, M_VALID, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0});
    // --------------------------------------------------
    // SFENCE capture
    // --------------------------------------------------
    vectors.push_back('{"sf_track_1", ex_pkg::ADD, 0, 0, 0, 0, 4'b0000, 0, 0, 0, 0, 'h1000, 'hA,
        0, 0, 0, M_SFENCE, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0});
    vectors.push_back('{"sf_track_2", ex_pkg::ADD, 0, 0, 0, 0, 4'b0000, 0, 0, 0, 0, 'h2000, 'hB,
        0, 0, 0, M_SFENCE, 0, 0, 0, 0, 0, 0, 0, 0, 'h1000, 'hA});
    vectors.push_back('{"sf_issue", ex_pkg::SFENCE_VMA, 0, 0, 0, 1, 4'b0010, 0, 0, 0, 0, 'h3000,
        'hC, 0, 0, 0, M_SFENCE, 0, 0, 0, 0, 0, 0, 0, 0, 'h2000, 'hB});
    vectors.push_back('{"sf_hold", ex_pkg::ADD, 0, 0, 0, 0, 4'b0000, 0, 0, 0, 0, 'h4000, 'hD,
        0, 0, 0, M_SFENCE, 0, 0, 0, 0, 0, 0, 0, 0, 'h2000, 'hB});
    vectors.push_back('{"sf_flush", ex_pkg::ADD, 0, 0, 0, 0, 4'b0000, 0, 0, 0, 0, 'h5000, 'hE,
        1, 0, 0, M_SFENCE, 0, 0, 0, 0, 0, 0, 0, 0, 'h2000, 'hB});
    vectors.push_back('{"sf_released", ex_pkg::ADD, 0, 0, 0, 0, 4'b0000, 0, 0, 0, 0, 'h6000, 'hF,
        0, 0, 0, M_SFENCE, 0, 0, 0, 0, 0, 0, 0, 0, 'h2000, 'hB});
    vectors.push_back('{"sf_tracking", ex_pkg::ADD, 0, 0, 0, 0, 4'b0000, 0, 0, 0, 0, 'h7000, 'h1,
        0, 0, 0, M_SFENCE, 0, 0, 0, 0, 0, 0, 0, 0, 'h6000, 'hF});
endtask

`endif

//--- test/tb_ex_stage.sv
// Testbench for the execute stage driving a per-cycle vector table
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage;

    localparam time PERIOD       = 100;
    localparam int  RESET_CYCLES = 3;

    logic                             clk_i;
    logic                             rst_ni;
    logic                             flush_i;
    ex_pkg::fu_data_t                 fu_data_i;
    ex_pkg::issue_t                   issue_i;
    logic [ex_pkg::VLEN-1:0]          pc_i;
    logic                             is_compressed_i;
    ex_pkg::bp_predict_t              branch_predict_i;
    logic                             csr_commit_i;
    logic [ex_pkg::VLEN-1:0]          rs1_forwarding_i;
    logic [ex_pkg::VLEN-1:0]          rs2_forwarding_i;
    logic [ex_pkg::XLEN-1:0]          flu_result_o;
    logic [ex_pkg::TRANS_ID_BITS-1:0] flu_trans_id_o;
    ex_pkg::exception_t               flu_exception_o;
    logic                             flu_valid_o;
    logic                             flu_ready_o;
    ex_pkg::bp_resolve_t              resolved_branch_o;
    logic                             resolve_branch_o;
    logic [ex_pkg::CSR_ADDR_BITS-1:0] csr_addr_o;
    logic [ex_pkg::VLEN-1:0]          sfence_vaddr_o;
    logic [ex_pkg::ASID_WIDTH-1:0]    sfence_asid_o;

    int errors;
    int seed;

    `include "tb_ex_vectors.svh"

    ex_stage i_dut (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .flush_i           (flush_i),
        .fu_data_i         (fu_data_i),
        .issue_i           (issue_i),
        .pc_i              (pc_i),
        .is_compressed_i   (is_compressed_i),
        .branch_predict_i  (branch_predict_i),
        .csr_commit_i      (csr_commit_i),
        .rs1_forwarding_i  (rs1_forwarding_i),
        .rs2_forwarding_i  (rs2_forwarding_i),
        .flu_result_o      (flu_result_o),
        .flu_trans_id_o    (flu_trans_id_o),
        .flu_exception_o   (flu_exception_o),
        .flu_valid_o       (flu_valid_o),
        .flu_ready_o       (flu_ready_o),
        .resolved_branch_o (resolved_branch_o),
        .resolve_branch_o  (resolve_branch_o),
        .csr_addr_o        (csr_addr_o),
        .sfence_vaddr_o    (sfence_vaddr_o),
        .sfence_asid_o     (sfence_asid_o)
    );

    always #(PERIOD / 2) clk_i = ~clk_i;

    // Reference ALU results from the instruction set rules
    function automatic logic [31:0] alu_expected(ex_pkg::fu_op_e op, logic [31:0] a,
                                                 logic [31:0] b);
        case (op)
            ex_pkg::ADD:  return a + b;
            ex_pkg::SUB:  return a - b;
            ex_pkg::AND:  return a & b;
            ex_pkg::OR:   return a | b;
            ex_pkg::XOR:  return a ^ b;
            ex_pkg::SLL:  return a << b[4:0];
            ex_pkg::SRL:  return a >> b[4:0];
            ex_pkg::SLTU: return (a < b) ? 32'd1 : 32'd0;
            default:      return 32'd0;
        endcase
    endfunction

    // Branch direction by the unsigned compare rules
    // JALR always jumps
    function automatic logic branch_taken(ex_pkg::fu_op_e op, logic [31:0] a,
                                          logic [31:0] b);
        case (op)
            ex_pkg::EQ:   return a == b;
            ex_pkg::NE:   return a != b;
            ex_pkg::LTU:  return a < b;
            ex_pkg::GEU:  return a >= b;
            ex_pkg::JALR: return 1'b1;
            default:      return 1'b0;
        endcase
    endfunction

    task automatic check_value(input string name, input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("ERROR %s %s: expected %h, actual %h", name, what, exp, act);
        end
    endtask

    // Inputs change just after the rising edge
    task automatic drive_row(input vec_row_t r, input logic [31:0] a, input logic [31:0] b);
        ex_pkg::fu_data_t    fd;
        ex_pkg::bp_predict_t bp;
        fd.operator        = r.op;
        fd.operand_a       = a;
        fd.operand_b       = b;
        fd.imm.offset      = r.imm;
        fd.trans_id        = r.tid;
        bp.taken           = r.pt;
        bp.predict_address = r.pa;
        fu_data_i        <= fd;
        issue_i          <= r.issue;
        pc_i             <= r.pc;
        is_compressed_i  <= r.cmpr;
        branch_predict_i <= bp;
        rs1_forwarding_i <= r.rs1;
        rs2_forwarding_i <= r.rs2;
        flush_i          <= r.flush;
        csr_commit_i     <= r.commit;
    endtask

    task automatic check_row(input vec_row_t r, input logic [31:0] exp_result);
        logic exp_taken;
        exp_taken = branch_taken(r.op, r.a, r.b);
        if (r.mask & M_VALID) begin
            check_value(r.name, "valid", r.valid, flu_valid_o);
            check_value(r.name, "resolve", r.issue[2], resolve_branch_o);
        end
        if (r.mask & M_RESULT) check_value(r.name, "result", exp_result, flu_result_o);
        if (r.mask & M_TID) check_value(r.name, "trans_id", r.rtid, flu_trans_id_o);
        if (r.mask & M_READY) check_value(r.name, "ready", r.ready, flu_ready_o);
        if (r.mask & M_BRANCH) begin
            check_value(r.name, "branch_valid", r.issue[2], resolved_branch_o.valid);
            check_value(r.name, "branch_pc", r.pc, resolved_branch_o.pc);
            check_value(r.name, "taken", exp_taken, resolved_branch_o.is_taken);
            check_value(r.name, "target", r.target, resolved_branch_o.target);
            check_value(r.name, "mispredict", r.misp, resolved_branch_o.is_mispredict);
            check_value(r.name, "exception", r.exc, flu_exception_o.valid);
            // Instruction address misaligned is cause 0
            if (r.exc) begin
                check_value(r.name, "cause", 32'd0, flu_exception_o.cause);
                check_value(r.name, "tval", r.target, flu_exception_o.tval);
            end
        end
        if (r.mask & M_CSR) check_value(r.name, "csr_addr", r.csr, csr_addr_o);
        if (r.mask & M_SFENCE) begin
            check_value(r.name, "sfence_vaddr", r.vaddr, sfence_vaddr_o);
            check_value(r.name, "sfence_asid", r.asid, sfence_asid_o);
        end
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        vec_row_t    r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] exp_result;
        errors           = 0;
        seed             = 56;
        clk_i            = 1'b0;
        rst_ni           = 1'b0;
        flush_i          = 1'b0;
        fu_data_i        = '0;
        issue_i          = '0;
        pc_i             = '0;
        is_compressed_i  = 1'b0;
        branch_predict_i = '0;
        csr_commit_i     = 1'b0;
        rs1_forwarding_i = '0;
        rs2_forwarding_i = '0;
        load_vectors();
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_ni <= 1'b1;
        foreach (vectors[i]) begin
            r          = vectors[i];
            a          = r.a;
            b          = r.b;
            exp_result = r.result;
            // Random operands with results from the reference model
            if (r.rnd) begin
                a          = $random(seed);
                b          = $random(seed);
                exp_result = alu_expected(r.op, a, b);
            end
            @(posedge clk_i);
            drive_row(r, a, b);
            // Sample mid-cycle when outputs have settled
            @(negedge clk_i);
            check_row(r, exp_result);
        end
        @(posedge clk_i);
        issue_i <= '0;
        $display("Finished %0d rows with %0d errors", vectors.size(), errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Watchdog sized by the table length
    initial begin
        #1;
        #((vectors.size() + RESET_CYCLES + 10) * PERIOD);
        $display("Timeout: the vector loop did not finish in time");
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire
